/* sprite_data.hex */
// sprite bitmaps, one byte per line, address is sprite * 8 + line
// bit 0 of each byte is the leftmost column of the line
3c
06
0e
1e
3e
7e
66
42
01
03
07
0f
1f
3f
7f
ff
ff
81
81
f1
91
91
9f
00
0f
1e
3c
78
f0
e1
c3
87
aa
55
aa
55
f0
0f
f0
0f
07
05
07
00
e0
a0
e0
00
80
c0
60
30
18
0c
06
03
11
22
44
88
fe
7f
01
f8

/* frame_buffer_top.f */
logic/sprite_pkg.sv
logic/entity_detector.sv
logic/sprite_rom.sv
logic/pixel_shifter.sv
logic/frame_buffer_top.sv
sim/frame_buffer_checker.sv
sim/frame_buffer_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sprite renderer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f frame_buffer_top.f \
    --top-module frame_buffer_tb -o frame_buffer_sim

# the log carries the verdict, so a stopped run still gets inspected
./obj_dir/frame_buffer_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi
echo "simulation finished cleanly"

/* sim/frame_buffer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_tb;

    logic                     clk = 1'b0;
    logic                     reset;
    sprite_pkg::entity_t      entities [sprite_pkg::num_entities];
    sprite_pkg::pixel_count_t counter_h;
    sprite_pkg::pixel_count_t counter_v;
    logic                     colour;
    sprite_pkg::sprite_line_t line_out;

    // own copy of the bitmaps for the model
    sprite_pkg::sprite_line_t sprite_mem [sprite_pkg::num_sprites * sprite_pkg::sprite_lines];

    // expected {line, colour}, capture cycle and test name per pixel in flight
    logic [8:0] expect_queue [$];
    int         stamp_queue [$];
    string      name_queue [$];

    string  test_name;
    logic   pushing;
    logic   run_passed;
    logic   fail_reported;
    int     compared;
    integer seed;

    frame_buffer_top i_frame_buffer_top (
        .clk       (clk),
        .reset     (reset),
        .entity_0  (entities[0]),
        .entity_1  (entities[1]),
        .entity_2  (entities[2]),
        .entity_3  (entities[3]),
        .entity_4  (entities[4]),
        .entity_5  (entities[5]),
        .entity_6  (entities[6]),
        .entity_7  (entities[7]),
        .entity_8  (entities[8]),
        .counter_h (counter_h),
        .counter_v (counter_v),
        .colour    (colour),
        .line_out  (line_out)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // inputs move 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_pixel(input int h, input int v);
        next_cycle();
        counter_h = sprite_pkg::pixel_count_t'(h);
        counter_v = sprite_pkg::pixel_count_t'(v);
    endtask

    function automatic int rand_below(input int n);
        int unsigned r;
        r = $random(seed);
        return int'(r % $unsigned(n));
    endfunction

    function automatic sprite_pkg::entity_t make_entity(input int id, input int orient,
                                                        input int loc);
        return {4'(id), 2'(orient), 8'(loc)};
    endfunction

    // every slot free with ids 15 and 9 on random tiles
    task automatic clear_scene();
        for (int i = 0; i < sprite_pkg::num_entities; i++) begin
            entities[i] = make_entity((i % 2 == 0) ? 15 : 9, rand_below(4), rand_below(256));
        end
    endtask

    // raster over a rectangle at one pixel per cycle
    task automatic scan_area(input int h0, input int v0, input int width, input int height);
        for (int v = v0; v < v0 + height; v++) begin
            for (int h = h0; h < h0 + width; h++) begin
                apply_pixel(h, v);
            end
        end
    endtask

    task automatic random_counters(input int cycles, input int h_range, input int v_range);
        for (int c = 0; c < cycles; c++) begin
            apply_pixel(rand_below(h_range), rand_below(v_range));
        end
    endtask

    // expected {line, colour} straight from the scene rules
    function automatic logic [8:0] reference_pixel(
        input sprite_pkg::entity_t      ents [sprite_pkg::num_entities],
        input sprite_pkg::pixel_count_t h,
        input sprite_pkg::pixel_count_t v
    );
        int                       tile_col;
        int                       tile_row;
        int                       loc;
        int                       sprite_row;
        int                       sprite_col;
        logic                     found;
        sprite_pkg::sprite_line_t bits;
        sprite_pkg::sprite_line_t oriented;
        tile_col   = int'(h) / int'(sprite_pkg::tile_pixels);
        tile_row   = int'(v) / int'(sprite_pkg::tile_pixels);
        sprite_row = (int'(v) % int'(sprite_pkg::tile_pixels)) / int'(sprite_pkg::upscale);
        sprite_col = (int'(h) % int'(sprite_pkg::tile_pixels)) / int'(sprite_pkg::upscale);
        found      = 1'b0;
        oriented   = '0;
        // first visible slot with a real sprite on this tile
        for (int i = 0; i < sprite_pkg::num_entities; i++) begin
            loc = int'(ents[i][7:0]);
            if (!found && loc % 16 == tile_col && loc / 16 == tile_row
                && loc / 16 < int'(sprite_pkg::screen_tiles_v)
                && int'(ents[i][13:10]) < int'(sprite_pkg::num_sprites)) begin
                found = 1'b1;
                // flip top to bottom
                if (ents[i][9]) begin
                    sprite_row = int'(sprite_pkg::sprite_lines) - 1 - sprite_row;
                end
                bits = sprite_mem[int'(ents[i][13:10]) * int'(sprite_pkg::sprite_lines)
                                  + sprite_row];
                // mirror left to right
                for (int b = 0; b < sprite_pkg::sprite_lines; b++) begin
                    oriented[b] = ents[i][8] ? bits[int'(sprite_pkg::sprite_lines) - 1 - b]
                                             : bits[b];
                end
            end
        end
        if (found) begin
            return {oriented, oriented[sprite_col]};
        end else begin
            return {8'h00, 1'b1};
        end
    endfunction

    task automatic compare_colour(input string test, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_reported = 1'b1;
            $display("MISMATCH %s colour expected %0b actual %0b", test, expected, actual);
            $display("Regression failed");
            $fatal(1, "colour check stopped the run");
        end
    endtask

    task automatic compare_line(input string test, input sprite_pkg::sprite_line_t expected,
                                input sprite_pkg::sprite_line_t actual);
        if (actual !== expected) begin
            fail_reported = 1'b1;
            $display("MISMATCH %s line_out expected %02h actual %02h", test, expected, actual);
            $display("Regression failed");
            $fatal(1, "line check stopped the run");
        end
    endtask

    // outputs and inputs both stable at the falling edge
    initial begin : compare_process
        int         cycle;
        int         since_release;
        logic [8:0] expected;
        string      name;
        cycle         = 0;
        since_release = 0;
        forever begin
            @(negedge clk);
            // white and empty during reset and while the pipeline refills
            if (!reset || since_release < int'(sprite_pkg::pipe_latency)) begin
                compare_colour("reset", 1'b1, colour);
                compare_line("reset", '0, line_out);
            end
            // oldest pixel leaves the pipe pipe_latency cycles after capture
            if (stamp_queue.size() != 0
                && stamp_queue[0] + int'(sprite_pkg::pipe_latency) == cycle) begin
                expected = expect_queue.pop_front();
                name     = name_queue.pop_front();
                void'(stamp_queue.pop_front());
                compare_colour(name, expected[0], colour);
                compare_line(name, expected[8:1], line_out);
                compared++;
            end
            // capture what the DUT samples at the next rising edge
            if (pushing) begin
                if (!reset) begin
                    expected = {8'h00, 1'b1};
                end else begin
                    expected = reference_pixel(entities, counter_h, counter_v);
                end
                expect_queue.push_back(expected);
                stamp_queue.push_back(cycle);
                name_queue.push_back(test_name);
            end
            if (reset) begin
                since_release++;
            end
            cycle++;
        end
    end

    task automatic wait_for_drain(input int max_cycles);
        int waited;
        waited = 0;
        while (expect_queue.size() != 0 && waited < max_cycles) begin
            @(posedge clk);
            waited++;
        end
    endtask

    initial begin : stimulus
        int k;
        int loc;
        seed          = 32'h545c;
        run_passed    = 1'b0;
        fail_reported = 1'b0;
        compared      = 0;
        pushing       = 1'b1;
        test_name     = "reset";
        $readmemh("sprite_data.hex", sprite_mem);
        reset     = 1'b0;
        counter_h = '0;
        counter_v = '0;
        clear_scene();
        // black sprite pixel under the counters is hidden while in reset
        entities[0] = make_entity(0, 0, 0);
        repeat (2) next_cycle();
        reset = 1'b1;
        repeat (4) next_cycle();

        test_name = "empty_scene";
        clear_scene();
        random_counters(2000, 640, 480);

        // sprite 3 on row 5 column 7 scanned with its 8 neighbours
        for (int o = 0; o < 4; o++) begin
            test_name = $sformatf("orientation_%0d", o);
            clear_scene();
            entities[0] = make_entity(3, o, 5 * 16 + 7);
            scan_area(6 * 40, 4 * 40, 3 * 40, 3 * 40);
        end

        // free slots 0 and 1 lose to slot 2 and then slot 3 takes over
        test_name = "priority";
        clear_scene();
        entities[0] = make_entity(9, 0, 87);
        entities[1] = make_entity(12, 3, 87);
        entities[2] = make_entity(5, 1, 87);
        entities[3] = make_entity(2, 0, 87);
        entities[6] = make_entity(7, 2, 87);
        scan_area(280, 200, 40, 40);
        entities[2] = make_entity(14, 1, 87);
        scan_area(280, 200, 40, 40);

        // rows 12..15 with counters past the bottom edge too
        test_name = "off_screen";
        for (int i = 0; i < sprite_pkg::num_entities; i++) begin
            entities[i] = make_entity(rand_below(8), rand_below(4), 192 + rand_below(64));
        end
        entities[0] = make_entity(1, 0, 12 * 16 + 3);
        scan_area(120, 480, 40, 40);
        random_counters(3000, 640, 1024);

        // half the pixels aimed at an entity tile
        test_name = "random_scene";
        for (int s = 0; s < 80; s++) begin
            for (int i = 0; i < sprite_pkg::num_entities; i++) begin
                entities[i] = make_entity(rand_below(16), rand_below(4), rand_below(208));
            end
            for (int c = 0; c < 64; c++) begin
                if (rand_below(2) == 0) begin
                    k   = rand_below(sprite_pkg::num_entities);
                    loc = int'(entities[k][7:0]);
                    apply_pixel((loc % 16) * 40 + rand_below(40),
                                (loc / 16) * 40 + rand_below(40));
                end else begin
                    apply_pixel(rand_below(640), rand_below(480));
                end
            end
        end

        // let the last pixel be captured
        next_cycle();
        pushing = 1'b0;
        wait_for_drain(4 * int'(sprite_pkg::pipe_latency));
        if (expect_queue.size() != 0 || compared == 0) begin
            fail_reported = 1'b1;
            $display("pipeline did not drain in time or no pixel was compared");
            $display("Regression failed");
            $fatal(1, "end of run check stopped the run");
        end else begin
            run_passed = 1'b1;
            $display("Regression passed");
            $finish;
        end
    end

    // assertion stop or early exit lands here
    final begin
        if (!run_passed && !fail_reported) begin
            $display("simulation stopped before the end of the test sequence");
            $display("Regression failed");
        end
    end

endmodule

`default_nettype wire

/* sim/frame_buffer_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_checker (
    input logic                   clk,
    input logic                   reset,
    input logic                   hit,
    input sprite_pkg::sprite_id_t hit_sprite,
    input logic                   line_valid,
    input logic                   colour
);

    // reset blanks the screen to white
    reset_gives_white: assert property (@(posedge clk) !reset |=> colour)
        else $error("colour not white in the cycle after reset");

    // no line, background shows through
    no_line_gives_white: assert property (@(posedge clk) !line_valid |=> colour)
        else $error("colour not white one cycle after line_valid low");

    // free slots never reach the rom
    hit_has_real_sprite: assert property (
        @(posedge clk) hit |-> (hit_sprite < sprite_pkg::sprite_id_t'(sprite_pkg::num_sprites))
    ) else $error("hit raised for an unused sprite id");

endmodule

// one checker per top level instance
bind frame_buffer_top frame_buffer_checker i_frame_buffer_checker (
    .clk        (clk),
    .reset      (reset),
    .hit        (hit),
    .hit_sprite (hit_sprite),
    .line_valid (line_valid),
    .colour     (colour)
);

`default_nettype wire

/* logic/frame_buffer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_top (
    input  logic                     clk,
    input  logic                     reset,
    input  sprite_pkg::entity_t      entity_0,
    input  sprite_pkg::entity_t      entity_1,
    input  sprite_pkg::entity_t      entity_2,
    input  sprite_pkg::entity_t      entity_3,
    input  sprite_pkg::entity_t      entity_4,
    input  sprite_pkg::entity_t      entity_5,
    input  sprite_pkg::entity_t      entity_6,
    input  sprite_pkg::entity_t      entity_7,
    input  sprite_pkg::entity_t      entity_8,
    input  sprite_pkg::pixel_count_t counter_h,
    input  sprite_pkg::pixel_count_t counter_v,
    output logic                     colour,
    output sprite_pkg::sprite_line_t line_out
);

    // detector to rom
    logic                    hit;
    sprite_pkg::sprite_id_t  hit_sprite;
    sprite_pkg::orient_t     hit_orient;
    sprite_pkg::line_index_t hit_line;
    sprite_pkg::line_index_t hit_column;

    // rom to shifter
    logic                     line_valid;
    sprite_pkg::sprite_line_t line_data;
    sprite_pkg::line_index_t  line_column;

    // stage 1, which entity covers the pixel
    entity_detector i_entity_detector (
        .clk        (clk),
        .reset      (reset),
        .entity_0   (entity_0),
        .entity_1   (entity_1),
        .entity_2   (entity_2),
        .entity_3   (entity_3),
        .entity_4   (entity_4),
        .entity_5   (entity_5),
        .entity_6   (entity_6),
        .entity_7   (entity_7),
        .entity_8   (entity_8),
        .counter_h  (counter_h),
        .counter_v  (counter_v),
        .hit        (hit),
        .hit_sprite (hit_sprite),
        .hit_orient (hit_orient),
        .hit_line   (hit_line),
        .hit_column (hit_column)
    );

    // stage 2, oriented sprite line
    sprite_rom i_sprite_rom (
        .clk         (clk),
        .reset       (reset),
        .hit         (hit),
        .hit_sprite  (hit_sprite),
        .hit_orient  (hit_orient),
        .hit_line    (hit_line),
        .hit_column  (hit_column),
        .line_valid  (line_valid),
        .line_data   (line_data),
        .line_column (line_column)
    );

    // stage 3, colour bit out
    pixel_shifter i_pixel_shifter (
        .clk         (clk),
        .reset       (reset),
        .line_valid  (line_valid),
        .line_data   (line_data),
        .line_column (line_column),
        .colour      (colour),
        .line_out    (line_out)
    );

endmodule

`default_nettype wire

/* logic/pixel_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_shifter (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     line_valid,
    input  sprite_pkg::sprite_line_t line_data,
    input  sprite_pkg::line_index_t  line_column,
    output logic                     colour,
    output sprite_pkg::sprite_line_t line_out
);

    // values for the next edge
    logic                     next_colour;
    sprite_pkg::sprite_line_t next_line;

    // column selects one bit of the oriented line
    // no sprite here means white background and an empty line
    always_comb begin
        if (line_valid) begin
            next_colour = line_data[line_column];
            next_line   = line_data;
        end else begin
            next_colour = 1'b1;
            next_line   = '0;
        end
    end

    // reset shows a white screen
    always_ff @(posedge clk) begin
        if (!reset) begin
            colour   <= 1'b1;
            line_out <= '0;
        end else begin
            colour   <= next_colour;
            line_out <= next_line;
        end
    end

endmodule

`default_nettype wire

/* logic/sprite_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_rom (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    hit,
    input  sprite_pkg::sprite_id_t  hit_sprite,
    input  sprite_pkg::orient_t     hit_orient,
    input  sprite_pkg::line_index_t hit_line,
    input  sprite_pkg::line_index_t hit_column,
    output logic                    line_valid,
    output sprite_pkg::sprite_line_t line_data,
    output sprite_pkg::line_index_t line_column
);

    // 8 sprites of 8 lines, one byte per line
    sprite_pkg::sprite_line_t rom [sprite_pkg::num_sprites * sprite_pkg::sprite_lines];

    logic [$clog2(sprite_pkg::num_sprites * sprite_pkg::sprite_lines)-1:0] rom_addr;

    sprite_pkg::line_index_t  read_line;
    sprite_pkg::sprite_line_t raw_line;
    sprite_pkg::sprite_line_t oriented_line;

    initial begin
        $readmemh("sprite_data.hex", rom);
    end

    // vertical flip picks the mirrored line
    assign read_line = hit_orient[1]
                     ? sprite_pkg::line_index_t'(sprite_pkg::sprite_lines - 1 - hit_line)
                     : hit_line;

    // sprite * 8 + line, hit guarantees id below 8
    assign rom_addr = {hit_sprite[2:0], read_line};
    assign raw_line = rom[rom_addr];

    // horizontal mirror reverses the bit order
    always_comb begin
        oriented_line = raw_line;
        if (hit_orient[0]) begin
            for (int i = 0; i < sprite_pkg::sprite_lines; i++) begin
                oriented_line[i] = raw_line[sprite_pkg::sprite_lines - 1 - i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            line_valid <= 1'b0;
        end else begin
            line_valid <= hit;
        end
    end

    // line and column ride along with the valid flag
    always_ff @(posedge clk) begin
        line_data   <= oriented_line;
        line_column <= hit_column;
    end

endmodule

`default_nettype wire

/* logic/entity_detector.sv */
`timescale 1ns/1ps
`default_nettype none

module entity_detector (
    input  logic                     clk,
    input  logic                     reset,
    input  sprite_pkg::entity_t      entity_0,
    input  sprite_pkg::entity_t      entity_1,
    input  sprite_pkg::entity_t      entity_2,
    input  sprite_pkg::entity_t      entity_3,
    input  sprite_pkg::entity_t      entity_4,
    input  sprite_pkg::entity_t      entity_5,
    input  sprite_pkg::entity_t      entity_6,
    input  sprite_pkg::entity_t      entity_7,
    input  sprite_pkg::entity_t      entity_8,
    input  sprite_pkg::pixel_count_t counter_h,
    input  sprite_pkg::pixel_count_t counter_v,
    output logic                     hit,
    output sprite_pkg::sprite_id_t   hit_sprite,
    output sprite_pkg::orient_t      hit_orient,
    output sprite_pkg::line_index_t  hit_line,
    output sprite_pkg::line_index_t  hit_column
);

    // slots as an array for the scan
    sprite_pkg::entity_t entities [sprite_pkg::num_entities];

    // tile holding the pixel
    sprite_pkg::pixel_count_t tile_h;
    sprite_pkg::pixel_count_t tile_v;

    // pixel offset inside its tile, 0..39
    sprite_pkg::pixel_count_t offset_h;
    sprite_pkg::pixel_count_t offset_v;

    // one flag per slot
    logic [sprite_pkg::num_entities-1:0] match;

    // winner before the register
    logic                next_hit;
    sprite_pkg::entity_t next_entity;

    assign entities[0] = entity_0;
    assign entities[1] = entity_1;
    assign entities[2] = entity_2;
    assign entities[3] = entity_3;
    assign entities[4] = entity_4;
    assign entities[5] = entity_5;
    assign entities[6] = entity_6;
    assign entities[7] = entity_7;
    assign entities[8] = entity_8;

    // counters past 639 / 479 give tiles no entity can sit on
    assign tile_h   = sprite_pkg::pixel_count_t'(counter_h / sprite_pkg::tile_pixels);
    assign tile_v   = sprite_pkg::pixel_count_t'(counter_v / sprite_pkg::tile_pixels);
    assign offset_h = sprite_pkg::pixel_count_t'(counter_h % sprite_pkg::tile_pixels);
    assign offset_v = sprite_pkg::pixel_count_t'(counter_v % sprite_pkg::tile_pixels);

    for (genvar i = 0; i < sprite_pkg::num_entities; i++) begin : g_match
        // location split into tile column and row
        sprite_pkg::pixel_count_t loc_h;
        sprite_pkg::pixel_count_t loc_v;

        assign loc_h = sprite_pkg::pixel_count_t'(entities[i][7:0] % sprite_pkg::screen_tiles_h);
        assign loc_v = sprite_pkg::pixel_count_t'(entities[i][7:0] / sprite_pkg::screen_tiles_h);

        // same tile, visible row, real sprite id
        // rows 12..15 are off the bottom of the screen
        assign match[i] = (loc_h == tile_h) && (loc_v == tile_v)
                       && (loc_v < sprite_pkg::screen_tiles_v)
                       && (entities[i][13:10] < sprite_pkg::num_sprites);
    end

    // lowest slot wins, so scan downwards and let later hits overwrite
    always_comb begin
        next_hit    = 1'b0;
        next_entity = entities[0];
        for (int i = sprite_pkg::num_entities - 1; i >= 0; i--) begin
            if (match[i]) begin
                next_hit    = 1'b1;
                next_entity = entities[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            hit <= 1'b0;
        end else begin
            hit <= next_hit;
        end
    end

    // payload follows hit, only meaningful when hit is set
    always_ff @(posedge clk) begin
        hit_sprite <= next_entity[13:10];
        hit_orient <= next_entity[9:8];
        // downscale tile offset to sprite coordinates
        hit_line   <= sprite_pkg::line_index_t'(offset_v / sprite_pkg::upscale);
        hit_column <= sprite_pkg::line_index_t'(offset_h / sprite_pkg::upscale);
    end

endmodule

`default_nettype wire

/* logic/sprite_pkg.sv */
`default_nettype none

package sprite_pkg;

    // scene and sprite geometry

    // entity slots checked for every pixel
    localparam int unsigned num_entities = 9;

    // sprite ids 0..7 hold bitmaps, higher ids mark a free slot
    localparam int unsigned num_sprites = 8;

    // lines per sprite, also bits per line
    localparam int unsigned sprite_lines = 8;

    // each sprite bit covers 5 by 5 screen pixels
    localparam int unsigned upscale = 5;

    // tile edge, sprite_lines * upscale
    localparam int unsigned tile_pixels = 40;

    // 640 / 40 columns, 480 / 40 rows
    localparam int unsigned screen_tiles_h = 16;
    localparam int unsigned screen_tiles_v = 12;

    // counters to colour, one cycle per stage
    localparam int unsigned pipe_latency = 3;

    // entity slot
    //   [13:10] sprite id
    //   [9:8]   orientation
    //   [7:0]   tile location, row * 16 + column
    typedef logic [13:0] entity_t;

    // one screen counter from the video timing
    typedef logic [9:0] pixel_count_t;

    typedef logic [3:0] sprite_id_t;

    // bit 0 mirrors left to right, bit 1 flips top to bottom
    // 0 as stored, 1 mirrored, 2 flipped, 3 rotated 180
    typedef logic [1:0] orient_t;

    // sprite line, or sprite column inside a tile
    typedef logic [2:0] line_index_t;

    // bit 0 is the leftmost column
    typedef logic [7:0] sprite_line_t;

endpackage

`default_nettype wire
